/* hw/cache_cfg.svh */
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

//////////////////////////////////////////////////
// geometry
//////////////////////////////////////////////////

`define CACHE_ADDR_W 10 // word address, not byte address.
`define CACHE_DATA_W 32

`define CACHE_INDEX_W 4 // sixteen one-word lines.
`define CACHE_TAG_W (`CACHE_ADDR_W - `CACHE_INDEX_W)

//////////////////////////////////////////////////
// write buffer and identification
//////////////////////////////////////////////////

`define CACHE_WBUF_DEPTH 4 // must be a power of two.

`define CACHE_VERSION 32'h0000_0103

`endif

/* hw/cache_pkg.sv */
package cache_pkg;

   //////////////////////////////////////////////////
   // control port register map
   //////////////////////////////////////////////////

   typedef enum logic [3:0] {
      CTRL_HIT        = 4'd1, // read hits plus write hits.
      CTRL_MISS       = 4'd2,
      CTRL_READ_HIT   = 4'd3,
      CTRL_READ_MISS  = 4'd4,
      CTRL_WRITE_HIT  = 4'd5,
      CTRL_WRITE_MISS = 4'd6,
      CTRL_RESET_CNT  = 4'd7, // action, returns zero.
      CTRL_INVALIDATE = 4'd8, // action, returns zero.
      CTRL_BUF_EMPTY  = 4'd9,
      CTRL_BUF_FULL   = 4'd10,
      CTRL_VERSION    = 4'd11
   } ctrl_op_e;

   // data stage sequencing
   typedef enum logic [1:0] {
      DATA_IDLE,
      DATA_WAIT_EMPTY, // write waiting for a free buffer slot.
      DATA_MEM_READ,
      DATA_RESPOND
   } data_state_e;

endpackage

/* hw/cache_lookup.sv */
`timescale 1ns/1ps

`include "cache_cfg.svh"

module cache_lookup (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     req_valid,
   output logic                     req_ready,
   input  logic                     req_we,
   input  logic [`CACHE_ADDR_W-1:0] req_addr,
   input  logic [`CACHE_DATA_W-1:0] req_wdata,
   output logic                     s1_valid,
   input  logic                     s1_ready,
   output logic                     s1_we,
   output logic [`CACHE_ADDR_W-1:0] s1_addr,
   output logic [`CACHE_DATA_W-1:0] s1_wdata,
   output logic                     s1_hit,
   input  logic                     fill_en,
   input  logic [`CACHE_ADDR_W-1:0] fill_addr,
   input  logic                     invalidate
);

   localparam int lines = 1 << `CACHE_INDEX_W;

   logic [lines-1:0]          valid_bits;
   logic [`CACHE_TAG_W-1:0]   tags [lines];
   logic                      held;
   logic [`CACHE_INDEX_W-1:0] s1_index;
   logic [`CACHE_INDEX_W-1:0] fill_index;
   logic                      accept;

   assign s1_index   = s1_addr[`CACHE_INDEX_W-1:0];
   assign fill_index = fill_addr[`CACHE_INDEX_W-1:0];

   assign req_ready = !held || s1_ready; // free, or the held item moves on this edge.
   assign accept    = req_valid && req_ready;
   assign s1_valid  = held;

   // the tags are read in the transfer cycle, so a fill that already landed is seen.
   assign s1_hit = valid_bits[s1_index] &&
                   (tags[s1_index] == s1_addr[`CACHE_ADDR_W-1:`CACHE_INDEX_W]);

   //////////////////////////////////////////////////
   // request register
   //////////////////////////////////////////////////

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         held <= 1'b0;
      end else if (accept) begin
         held <= 1'b1;
      end else if (s1_ready) begin
         held <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         s1_we    <= req_we;
         s1_addr  <= req_addr;
         s1_wdata <= req_wdata;
      end
   end

   //////////////////////////////////////////////////
   // valid bits and tags
   //////////////////////////////////////////////////

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         valid_bits <= '0;
      end else if (invalidate) begin
         valid_bits <= '0; // wins over a fill in the same cycle.
      end else if (fill_en) begin
         valid_bits[fill_index] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (fill_en) begin
         tags[fill_index] <= fill_addr[`CACHE_ADDR_W-1:`CACHE_INDEX_W];
      end
   end

endmodule

/* hw/cache_data.sv */
`timescale 1ns/1ps

`include "cache_cfg.svh"

module cache_data (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     s1_valid,
   output logic                     s1_ready,
   input  logic                     s1_we,
   input  logic [`CACHE_ADDR_W-1:0] s1_addr,
   input  logic [`CACHE_DATA_W-1:0] s1_wdata,
   input  logic                     s1_hit,
   output logic                     resp_valid,
   input  logic                     resp_ready,
   output logic [`CACHE_DATA_W-1:0] resp_rdata,
   output logic                     fill_en,
   output logic [`CACHE_ADDR_W-1:0] fill_addr,
   output logic                     wb_push,
   output logic [`CACHE_ADDR_W-1:0] wb_addr,
   output logic [`CACHE_DATA_W-1:0] wb_data,
   input  logic                     wb_full,
   output logic                     rd_valid,
   input  logic                     rd_ready,
   output logic [`CACHE_ADDR_W-1:0] rd_addr,
   input  logic [`CACHE_DATA_W-1:0] rd_data,
   output logic                     ev_read_hit,
   output logic                     ev_read_miss,
   output logic                     ev_write_hit,
   output logic                     ev_write_miss
);
   import cache_pkg::*;

   localparam int lines = 1 << `CACHE_INDEX_W;

   data_state_e               state;
   logic                      pend; // request captured, decision in this cycle.
   logic                      d_we;
   logic                      d_hit;
   logic [`CACHE_ADDR_W-1:0]  d_addr;
   logic [`CACHE_DATA_W-1:0]  d_wdata;
   logic [`CACHE_INDEX_W-1:0] d_index;
   logic [`CACHE_DATA_W-1:0]  rdata_q;
   logic [`CACHE_DATA_W-1:0]  data_mem [lines];
   logic                      decide;
   logic                      leave;
   logic                      take;

   assign d_index = d_addr[`CACHE_INDEX_W-1:0];
   assign decide  = (state == DATA_IDLE) && pend;
   assign leave   = (state == DATA_RESPOND) && resp_ready;
   assign s1_ready = ((state == DATA_IDLE) && !pend) || leave;
   assign take     = s1_valid && s1_ready;

   assign resp_valid = (state == DATA_RESPOND);
   assign resp_rdata = rdata_q;

   assign wb_push = d_we && !wb_full && (decide || (state == DATA_WAIT_EMPTY));
   assign wb_addr = d_addr;
   assign wb_data = d_wdata;

   assign rd_valid  = (state == DATA_MEM_READ);
   assign rd_addr   = d_addr;
   assign fill_en   = rd_valid && rd_ready; // line and tag land together.
   assign fill_addr = d_addr;

   assign ev_read_hit   = leave && !d_we && d_hit;
   assign ev_read_miss  = leave && !d_we && !d_hit;
   assign ev_write_hit  = leave && d_we && d_hit;
   assign ev_write_miss = leave && d_we && !d_hit;

   //////////////////////////////////////////////////
   // sequencing
   //////////////////////////////////////////////////

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state <= DATA_IDLE;
         pend  <= 1'b0;
      end else begin
         pend <= take;
         case (state)
            DATA_IDLE: begin
               if (pend) begin
                  if (d_we) begin
                     state <= wb_full ? DATA_WAIT_EMPTY : DATA_RESPOND;
                  end else begin
                     state <= d_hit ? DATA_RESPOND : DATA_MEM_READ;
                  end
               end
            end
            DATA_WAIT_EMPTY: if (!wb_full) state <= DATA_RESPOND;
            DATA_MEM_READ:   if (rd_ready) state <= DATA_RESPOND;
            DATA_RESPOND:    if (resp_ready) state <= DATA_IDLE;
            default:         state <= DATA_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         d_we    <= s1_we;
         d_hit   <= s1_hit;
         d_addr  <= s1_addr;
         d_wdata <= s1_wdata;
      end
      if (decide) begin
         rdata_q <= d_we ? '0 : data_mem[d_index]; // writes answer with zero.
      end else if (fill_en) begin
         rdata_q <= rd_data;
      end
   end

   // no allocate on a write miss, so only hits touch the array.
   always_ff @(posedge clk) begin
      if (fill_en) begin
         data_mem[d_index] <= rd_data;
      end else if (wb_push && d_hit) begin
         data_mem[d_index] <= d_wdata;
      end
   end

endmodule

/* hw/cache_mem_port.sv */
`timescale 1ns/1ps

`include "cache_cfg.svh"

module cache_mem_port #(
   parameter int depth = `CACHE_WBUF_DEPTH
) (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     wb_push,
   input  logic [`CACHE_ADDR_W-1:0] wb_addr,
   input  logic [`CACHE_DATA_W-1:0] wb_data,
   output logic                     wb_full,
   output logic                     wb_empty,
   input  logic                     rd_valid,
   output logic                     rd_ready,
   input  logic [`CACHE_ADDR_W-1:0] rd_addr,
   output logic [`CACHE_DATA_W-1:0] rd_data,
   output logic                     mem_valid,
   output logic                     mem_we,
   output logic [`CACHE_ADDR_W-1:0] mem_addr,
   output logic [`CACHE_DATA_W-1:0] mem_wdata,
   input  logic                     mem_ready,
   input  logic [`CACHE_DATA_W-1:0] mem_rdata
);

   localparam int ptr_w = $clog2(depth);

   logic [`CACHE_ADDR_W-1:0] fifo_addr [depth];
   logic [`CACHE_DATA_W-1:0] fifo_data [depth];
   logic [ptr_w:0]           wr_ptr; // extra bit tells full from empty.
   logic [ptr_w:0]           rd_ptr;
   logic [ptr_w-1:0]         head;
   logic                     pop;

   assign head     = rd_ptr[ptr_w-1:0];
   assign wb_empty = (wr_ptr == rd_ptr);
   assign wb_full  = (wr_ptr[ptr_w] != rd_ptr[ptr_w]) &&
                     (wr_ptr[ptr_w-1:0] == rd_ptr[ptr_w-1:0]);

   //////////////////////////////////////////////////
   // memory bus
   //////////////////////////////////////////////////

   // buffered writes go first, so a read never passes an older write.
   assign mem_valid = !wb_empty || rd_valid;
   assign mem_we    = !wb_empty;
   assign mem_addr  = wb_empty ? rd_addr : fifo_addr[head];
   assign mem_wdata = fifo_data[head];

   assign pop      = !wb_empty && mem_ready;
   assign rd_ready = wb_empty && rd_valid && mem_ready;
   assign rd_data  = mem_rdata; // valid only in the completing cycle.

   //////////////////////////////////////////////////
   // write FIFO
   //////////////////////////////////////////////////

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wb_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wb_push) begin
         fifo_addr[wr_ptr[ptr_w-1:0]] <= wb_addr;
         fifo_data[wr_ptr[ptr_w-1:0]] <= wb_data;
      end
   end

endmodule

/* hw/cache_control.sv */
`timescale 1ns/1ps

`include "cache_cfg.svh"

module cache_control (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     ctrl_valid,
   input  cache_pkg::ctrl_op_e      ctrl_addr,
   output logic [`CACHE_DATA_W-1:0] ctrl_rdata,
   output logic                     ctrl_ready,
   output logic                     invalidate,
   input  logic                     wb_empty,
   input  logic                     wb_full,
   input  logic                     ev_read_hit,
   input  logic                     ev_read_miss,
   input  logic                     ev_write_hit,
   input  logic                     ev_write_miss
);
   import cache_pkg::*;

   logic [`CACHE_DATA_W-1:0] read_hit_cnt;
   logic [`CACHE_DATA_W-1:0] read_miss_cnt;
   logic [`CACHE_DATA_W-1:0] write_hit_cnt;
   logic [`CACHE_DATA_W-1:0] write_miss_cnt;
   logic [`CACHE_DATA_W-1:0] hit_cnt;
   logic [`CACHE_DATA_W-1:0] miss_cnt;
   logic [`CACHE_DATA_W-1:0] sel_value;
   logic                     counter_reset;

   assign hit_cnt  = read_hit_cnt + write_hit_cnt;
   assign miss_cnt = read_miss_cnt + write_miss_cnt;

   //////////////////////////////////////////////////
   // performance counters
   //////////////////////////////////////////////////

   // events exclude each other, so each one touches a single counter.
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         read_hit_cnt   <= '0;
         read_miss_cnt  <= '0;
         write_hit_cnt  <= '0;
         write_miss_cnt <= '0;
      end else if (counter_reset) begin
         read_hit_cnt   <= '0;
         read_miss_cnt  <= '0;
         write_hit_cnt  <= '0;
         write_miss_cnt <= '0;
      end else begin
         if (ev_read_hit) read_hit_cnt <= read_hit_cnt + 1'b1;
         if (ev_read_miss) read_miss_cnt <= read_miss_cnt + 1'b1;
         if (ev_write_hit) write_hit_cnt <= write_hit_cnt + 1'b1;
         if (ev_write_miss) write_miss_cnt <= write_miss_cnt + 1'b1;
      end
   end

   //////////////////////////////////////////////////
   // register port
   //////////////////////////////////////////////////

   always_comb begin
      case (ctrl_addr)
         CTRL_HIT:        sel_value = hit_cnt;
         CTRL_MISS:       sel_value = miss_cnt;
         CTRL_READ_HIT:   sel_value = read_hit_cnt;
         CTRL_READ_MISS:  sel_value = read_miss_cnt;
         CTRL_WRITE_HIT:  sel_value = write_hit_cnt;
         CTRL_WRITE_MISS: sel_value = write_miss_cnt;
         CTRL_BUF_EMPTY:  sel_value = {{(`CACHE_DATA_W-1){1'b0}}, wb_empty};
         CTRL_BUF_FULL:   sel_value = {{(`CACHE_DATA_W-1){1'b0}}, wb_full};
         CTRL_VERSION:    sel_value = `CACHE_VERSION;
         default:         sel_value = '0; // actions read back as zero.
      endcase
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ctrl_ready    <= 1'b0;
         invalidate    <= 1'b0;
         counter_reset <= 1'b0;
      end else begin
         ctrl_ready    <= ctrl_valid; // acknowledge one cycle after the access.
         invalidate    <= ctrl_valid && (ctrl_addr == CTRL_INVALIDATE);
         counter_reset <= ctrl_valid && (ctrl_addr == CTRL_RESET_CNT);
      end
   end

   always_ff @(posedge clk) begin
      ctrl_rdata <= ctrl_valid ? sel_value : '0;
   end

endmodule

/* hw/cache_top.sv */
`timescale 1ns/1ps

`include "cache_cfg.svh"

module cache_top (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     req_valid,
   output logic                     req_ready,
   input  logic                     req_we,
   input  logic [`CACHE_ADDR_W-1:0] req_addr,
   input  logic [`CACHE_DATA_W-1:0] req_wdata,
   output logic                     resp_valid,
   input  logic                     resp_ready,
   output logic [`CACHE_DATA_W-1:0] resp_rdata,
   output logic                     mem_valid,
   output logic                     mem_we,
   output logic [`CACHE_ADDR_W-1:0] mem_addr,
   output logic [`CACHE_DATA_W-1:0] mem_wdata,
   input  logic                     mem_ready,
   input  logic [`CACHE_DATA_W-1:0] mem_rdata,
   input  logic                     ctrl_valid,
   input  cache_pkg::ctrl_op_e      ctrl_addr,
   output logic [`CACHE_DATA_W-1:0] ctrl_rdata,
   output logic                     ctrl_ready
);

   logic                     s1_valid, s1_ready, s1_we, s1_hit;
   logic [`CACHE_ADDR_W-1:0] s1_addr;
   logic [`CACHE_DATA_W-1:0] s1_wdata;
   logic                     fill_en, invalidate;
   logic [`CACHE_ADDR_W-1:0] fill_addr;
   logic                     wb_push, wb_full, wb_empty;
   logic [`CACHE_ADDR_W-1:0] wb_addr;
   logic [`CACHE_DATA_W-1:0] wb_data;
   logic                     rd_valid, rd_ready;
   logic [`CACHE_ADDR_W-1:0] rd_addr;
   logic [`CACHE_DATA_W-1:0] rd_data;
   logic                     ev_read_hit, ev_read_miss, ev_write_hit, ev_write_miss;

   cache_lookup i_cache_lookup (.*);

   cache_data i_cache_data (.*);

   cache_mem_port #(
      .depth(`CACHE_WBUF_DEPTH)
   ) i_cache_mem_port (.*);

   cache_control i_cache_control (.*);

endmodule

/* dv/cache_asserts.sv */
`timescale 1ns/1ps

module cache_asserts (
   input logic clk,
   input logic reset,
   input logic resp_valid,
   input logic resp_ready,
   input logic ctrl_valid,
   input logic ctrl_ready,
   input logic wb_push,
   input logic wb_full,
   input logic ev_read_hit,
   input logic ev_read_miss,
   input logic ev_write_hit,
   input logic ev_write_miss
);

   one_event: assert property (@(posedge clk) disable iff (reset)
      $onehot0({ev_read_hit, ev_read_miss, ev_write_hit, ev_write_miss}))
      else $error("more than one event pulse in a cycle");

   ctrl_follows: assert property (@(posedge clk) disable iff (reset)
      ctrl_ready == $past(ctrl_valid))
      else $error("ctrl_ready does not follow ctrl_valid by one cycle");

   resp_held: assert property (@(posedge clk) disable iff (reset)
      resp_valid && !resp_ready |=> resp_valid)
      else $error("resp_valid dropped before resp_ready");

   push_not_full: assert property (@(posedge clk) disable iff (reset)
      !(wb_push && wb_full))
      else $error("write pushed into a full buffer");

endmodule

bind cache_top cache_asserts i_cache_asserts (.*);

/* dv/cache_tb.sv */
`timescale 1ns/1ps

`include "cache_cfg.svh"

module cache_tb;
   import cache_pkg::*;

   localparam int aw = `CACHE_ADDR_W;
   localparam int dw = `CACHE_DATA_W;
   localparam int iw = `CACHE_INDEX_W;
   localparam int clk_period = 100;
   localparam int n_ops = 400;
   localparam int n_batches = 8;
   localparam logic [aw-1:0] window = 10'h2e0; // 32 words, two tags per line.

   logic                 clk, reset;
   logic                 req_valid, req_ready, req_we;
   logic [aw-1:0]        req_addr;
   logic [dw-1:0]        req_wdata;
   logic                 resp_valid, resp_ready;
   logic [dw-1:0]        resp_rdata;
   logic                 mem_valid, mem_we, mem_ready;
   logic [aw-1:0]        mem_addr;
   logic [dw-1:0]        mem_wdata, mem_rdata;
   logic                 ctrl_valid, ctrl_ready;
   ctrl_op_e             ctrl_addr;
   logic [dw-1:0]        ctrl_rdata;

   logic [31:0]          lfsr = 32'hf0347ce8;
   logic [dw-1:0]        ref_mem [1 << aw];
   logic [dw-1:0]        bus_mem [1 << aw];
   logic [(1 << iw)-1:0] shadow_valid;
   logic [aw-iw-1:0]     shadow_tag [1 << iw];
   logic [dw-1:0]        rd_hits, rd_misses, wr_hits, wr_misses;
   logic [dw-1:0]        exp_q [$];
   logic [aw-1:0]        wr_addr_q [$];
   logic [dw-1:0]        wr_data_q [$];
   logic                 req_taken, ctrl_seen;
   logic [dw-1:0]        ctrl_value;

   cache_top i_cache_top (.*);

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   initial begin
      #(n_ops * 60 * clk_period);
      $display("Timeout: the run did not finish within %0d cycles", n_ops * 60);
      abort_run();
   end

   //////////////////////////////////////////////////
   // helpers and compare tasks
   //////////////////////////////////////////////////

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1; // galois step.
         v = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic logic [dw-1:0] fill_word(input logic [aw-1:0] a);
      return {6'h2a, a, ~a, 6'h15};
   endfunction

   function automatic logic [dw-1:0] model_count(input ctrl_op_e op);
      case (op)
         CTRL_HIT:        return rd_hits + wr_hits;
         CTRL_MISS:       return rd_misses + wr_misses;
         CTRL_READ_HIT:   return rd_hits;
         CTRL_READ_MISS:  return rd_misses;
         CTRL_WRITE_HIT:  return wr_hits;
         CTRL_WRITE_MISS: return wr_misses;
         default:         return '0;
      endcase
   endfunction

   task automatic abort_run();
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic compare_word(input string name, input logic [dw-1:0] got,
                               input logic [dw-1:0] exp);
      if (got !== exp) begin
         $display("Error: %s got %h expected %h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic compare_addr(input string name, input logic [aw-1:0] got,
                               input logic [aw-1:0] exp);
      if (got !== exp) begin
         $display("Error: %s got %h expected %h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic compare_count(input ctrl_op_e op, input logic [dw-1:0] got,
                                input logic [dw-1:0] exp);
      if (got !== exp) begin
         $display("Error: ctrl_rdata for %s got %h expected %h", op.name(), got, exp);
         abort_run();
      end
   endtask

   //////////////////////////////////////////////////
   // one clock cycle: sample at the falling edge, drive after the rising edge
   //////////////////////////////////////////////////

   task automatic tick();
      @(negedge clk);
      req_taken  = req_valid && req_ready;
      ctrl_seen  = ctrl_ready;
      ctrl_value = ctrl_rdata;
      if (mem_valid && mem_ready && mem_we) begin
         if (wr_addr_q.size() == 0) begin
            $display("A write appeared on the memory bus that no request issued");
            abort_run();
         end
         compare_addr("mem_addr", mem_addr, wr_addr_q.pop_front());
         compare_word("mem_wdata", mem_wdata, wr_data_q.pop_front());
         bus_mem[mem_addr] = mem_wdata;
      end
      if (resp_valid && resp_ready) begin
         if (exp_q.size() == 0) begin
            $display("A response arrived with no request outstanding");
            abort_run();
         end
         compare_word("resp_rdata", resp_rdata, exp_q.pop_front());
      end
      @(posedge clk);
      #1;
      mem_ready  = (rand_bits(2) != 0); // memory stalls about one cycle in four.
      mem_rdata  = bus_mem[mem_addr];
      resp_ready = (rand_bits(2) != 0);
   endtask

   task automatic send_request(input logic we, input logic [aw-1:0] addr,
                               input logic [dw-1:0] data);
      logic [iw-1:0] idx;
      logic          hit;
      idx = addr[iw-1:0];
      hit = shadow_valid[idx] && (shadow_tag[idx] == addr[aw-1:iw]);
      if (we) begin
         if (hit) wr_hits++;
         else wr_misses++;
         ref_mem[addr] = data;
         wr_addr_q.push_back(addr);
         wr_data_q.push_back(data);
         exp_q.push_back('0);
      end else begin
         if (hit) begin
            rd_hits++;
         end else begin
            rd_misses++;
            shadow_valid[idx] = 1'b1; // read miss allocates the line.
            shadow_tag[idx]   = addr[aw-1:iw];
         end
         exp_q.push_back(ref_mem[addr]);
      end
      req_valid = 1'b1;
      req_we    = we;
      req_addr  = addr;
      req_wdata = data;
      do begin
         tick();
      end while (!req_taken);
      req_valid = 1'b0;
   endtask

   task automatic wait_quiet();
      while (exp_q.size() != 0 || wr_addr_q.size() != 0) begin
         tick();
      end
      tick();
   endtask

   task automatic ctrl_access(input ctrl_op_e op, output logic [dw-1:0] value);
      ctrl_valid = 1'b1;
      ctrl_addr  = op;
      tick();
      ctrl_valid = 1'b0;
      do begin
         tick();
      end while (!ctrl_seen);
      value = ctrl_value;
   endtask

   task automatic check_counters();
      ctrl_op_e      op;
      logic [dw-1:0] got;
      op = CTRL_HIT;
      repeat (6) begin
         ctrl_access(op, got);
         compare_count(op, got, model_count(op));
         op = op.next();
      end
   endtask

   task automatic check_memory();
      for (int a = 0; a < (1 << aw); a++) begin
         compare_word($sformatf("bus_mem[%h]", a[aw-1:0]), bus_mem[a], ref_mem[a]);
      end
   endtask

   //////////////////////////////////////////////////
   // test sequence
   //////////////////////////////////////////////////

   initial begin
      logic [dw-1:0] value;
      logic [31:0]   r;
      logic [aw-1:0] addr;
      logic          we;
      reset      = 1'b1;
      req_valid  = 1'b0;
      req_we     = 1'b0;
      req_addr   = '0;
      req_wdata  = '0;
      resp_ready = 1'b0;
      mem_ready  = 1'b0;
      mem_rdata  = '0;
      ctrl_valid = 1'b0;
      ctrl_addr  = CTRL_VERSION;
      shadow_valid = '0;
      rd_hits    = '0;
      rd_misses  = '0;
      wr_hits    = '0;
      wr_misses  = '0;
      for (int a = 0; a < (1 << aw); a++) begin
         ref_mem[a] = fill_word(a[aw-1:0]);
         bus_mem[a] = fill_word(a[aw-1:0]);
      end
      repeat (8) @(posedge clk);
      #1;
      reset = 1'b0;

      ctrl_access(CTRL_VERSION, value);
      compare_count(CTRL_VERSION, value, `CACHE_VERSION);
      for (int b = 0; b < n_batches; b++) begin
         repeat (n_ops / n_batches) begin
            r = rand_bits(2);
            if (r[1:0] == 2'b00) tick();
            r    = rand_bits(5);
            addr = window | r[aw-1:0];
            r    = rand_bits(1);
            we   = r[0];
            send_request(we, addr, rand_bits(32));
         end
         wait_quiet();
         check_memory();
         check_counters();
         ctrl_access(CTRL_BUF_EMPTY, value);
         compare_count(CTRL_BUF_EMPTY, value, 1);
         ctrl_access(CTRL_BUF_FULL, value);
         compare_count(CTRL_BUF_FULL, value, 0);

         // a cached line must miss again after invalidation.
         addr = window + b[aw-1:0];
         send_request(1'b0, addr, '0);
         wait_quiet();
         ctrl_access(CTRL_INVALIDATE, value);
         shadow_valid = '0;
         ctrl_access(CTRL_RESET_CNT, value);
         rd_hits   = '0;
         rd_misses = '0;
         wr_hits   = '0;
         wr_misses = '0;
         check_counters();
         send_request(1'b0, addr, '0);
         wait_quiet();
         ctrl_access(CTRL_READ_MISS, value);
         compare_count(CTRL_READ_MISS, value, 1);
      end
      $display("Test completed successfully");
      $finish;
   end

endmodule

/* build.f */
+incdir+hw
hw/cache_pkg.sv
hw/cache_lookup.sv
hw/cache_data.sv
hw/cache_mem_port.sv
hw/cache_control.sv
hw/cache_top.sv
dv/cache_asserts.sv
dv/cache_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module cache_tb \
		-f build.f -o cache_sim
	./obj_dir/cache_sim | grep "Test completed successfully"

clean:
	rm -rf obj_dir
